// ==== bench/soc_trace.txt ====
# op mst we adr dat sel exp err lat, all in hex
# op 0 access, 1 both masters write (exp holds the CPU data), 2 irq_o, 3 uart byte, 4 poll
# mst 0 cpu, 1 debug; lat is ack cycles after the request, 0 means held back
2 0 0 00000000 00000000 0 00000000 0 0
0 0 1 00000010 11223344 f 00000000 0 2
0 1 0 00000010 00000000 f 11223344 0 2
0 1 1 00000010 aabbccdd 5 00000000 0 2
0 0 0 00000010 00000000 f 11bb33dd 0 2
0 0 1 00000020 01020304 f 00000000 0 2
0 1 1 00000020 99887766 c 00000000 0 2
0 1 0 00000020 00000000 f 99880304 0 2
0 0 0 40000000 00000000 f 00000000 1 2
0 1 1 00000400 12345678 f 00000000 1 2
1 0 1 00000030 d0d0d0d0 f c0c0c0c0 0 0
0 1 0 00000030 00000000 f c0c0c0c0 0 2
0 0 1 90000004 00000001 f 00000000 0 2
2 0 0 00000000 00000000 0 00000004 0 0
0 1 0 90000004 00000000 f 00000001 0 2
0 0 1 90000000 00000055 1 00000000 0 2
0 0 1 90000000 000000a3 1 00000000 0 0
0 1 0 90000000 00000000 f 00000001 0 2
2 0 0 00000000 00000000 0 00000000 0 0
3 0 0 00000000 00000000 0 00000055 0 0
3 0 0 00000000 00000000 0 000000a3 0 0
4 0 0 90000000 00000000 f 00000000 0 0
2 0 0 00000000 00000000 0 00000004 0 0
0 0 1 90000004 00000000 f 00000000 0 2
2 0 0 00000000 00000000 0 00000000 0 0
0 1 0 90000004 00000000 f 00000000 0 2

// ==== compile.f ====
verilog/soc_pkg.sv
verilog/wb_intercon.sv
verilog/wb_ram.sv
verilog/wb_uart_tx.sv
verilog/soc_top.sv
bench/soc_assertions.sv
bench/tb_soc.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_soc
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_soc.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_soc;

	localparam int ACK_TIMEOUT  = 200;
	localparam int BYTE_TIMEOUT = 1000;
	localparam int POLL_LIMIT   = 100;

	logic             wb_clk;
	logic             rst_n;
	soc_pkg::wb_m2s_t cpu_m2s;
	soc_pkg::wb_m2s_t dbg_m2s;
	soc_pkg::wb_s2m_t cpu_s2m;
	soc_pkg::wb_s2m_t dbg_s2m;
	logic             uart_tx;
	logic [31:0]      irq;
	logic [7:0]       rx_bytes [$];

	soc_top u_dut (
		.wb_clk_i  (wb_clk),
		.rst_n_i   (rst_n),
		.cpu_m2s_i (cpu_m2s),
		.cpu_s2m_o (cpu_s2m),
		.dbg_m2s_i (dbg_m2s),
		.dbg_s2m_o (dbg_s2m),
		.uart_tx_o (uart_tx),
		.irq_o     (irq)
	);

	always #5 wb_clk = ~wb_clk;

	//////////////////////////////
	// Checks
	//////////////////////////////

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic check_s2m(input string name, input soc_pkg::wb_s2m_t got,
	                         input soc_pkg::wb_s2m_t exp, input logic with_dat);
		if (got.ack !== exp.ack || got.err !== exp.err || (with_dat && got.dat !== exp.dat))
			stop_run($sformatf("Mismatch %s: got dat=%h ack=%h err=%h, expected %s",
			                   name, got.dat, got.ack, got.err,
			                   $sformatf("dat=%h ack=%h err=%h", exp.dat, exp.ack, exp.err)));
	endtask

	task automatic check_irq(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stop_run($sformatf("Mismatch irq_o: got %h expected %h", got, exp));
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			stop_run($sformatf("Mismatch uart_tx_o byte: got %h expected %h", got, exp));
	endtask

	// Zero stands for a write that must be held back
	task automatic check_latency(input string name, input int got, input int exp);
		if (exp == 0 && got <= 2)
			stop_run($sformatf("%s answered after %0d cycles although the UART was busy",
			                   name, got));
		else if (exp != 0 && got != exp)
			stop_run($sformatf("Mismatch %s latency: got %h expected %h", name, got, exp));
	endtask

	//////////////////////////////
	// Bus tasks
	//////////////////////////////

	task automatic drive_master(input int mst, input soc_pkg::wb_m2s_t req);
		if (mst == 1)
			dbg_m2s <= req;
		else
			cpu_m2s <= req;
	endtask

	// Classic cycle released on the edge after ack or err
	task automatic transfer(input int mst, input logic we, input logic [31:0] adr,
	                        input logic [31:0] dat, input logic [3:0] sel,
	                        output soc_pkg::wb_s2m_t rsp, output int lat);
		int n;
		n = 0;
		rsp = '0;
		@(posedge wb_clk);
		drive_master(mst, {adr, dat, sel, we, 1'b1, 1'b1});
		while (!rsp.ack && !rsp.err) begin
			if (n == ACK_TIMEOUT)
				stop_run($sformatf("No ack or err came back for address %h", adr));
			@(negedge wb_clk);
			n++;
			rsp = (mst == 1) ? dbg_s2m : cpu_s2m;
		end
		lat = n - 1;
		@(posedge wb_clk);
		drive_master(mst, '0);
	endtask

	task automatic access(input int mst, input logic we, input logic [31:0] adr,
	                      input logic [31:0] dat, input logic [3:0] sel,
	                      input logic [31:0] exp, input logic err, input int lat);
		soc_pkg::wb_s2m_t rsp;
		soc_pkg::wb_s2m_t want;
		int               got_lat;
		string            name;
		name = (mst == 1) ? "dbg_s2m_o" : "cpu_s2m_o";
		transfer(mst, we, adr, dat, sel, rsp, got_lat);
		want = {exp, ~err, err};
		check_s2m(name, rsp, want, !we || err);
		check_latency(name, got_lat, lat);
	endtask

	// Debug wins the tie and the CPU follows once debug drops cyc
	task automatic both_write(input logic [31:0] adr, input logic [31:0] dbg_dat,
	                          input logic [31:0] cpu_dat, input logic [3:0] sel);
		soc_pkg::wb_s2m_t dbg_rsp;
		soc_pkg::wb_s2m_t cpu_rsp;
		int               dbg_lat;
		int               cpu_lat;
		time              dbg_t;
		time              cpu_t;
		fork
			begin
				transfer(1, 1'b1, adr, dbg_dat, sel, dbg_rsp, dbg_lat);
				dbg_t = $time;
			end
			begin
				transfer(0, 1'b1, adr, cpu_dat, sel, cpu_rsp, cpu_lat);
				cpu_t = $time;
			end
		join
		check_s2m("dbg_s2m_o", dbg_rsp, {32'h0, 1'b1, 1'b0}, 1'b0);
		check_s2m("cpu_s2m_o", cpu_rsp, {32'h0, 1'b1, 1'b0}, 1'b0);
		check_latency("dbg_s2m_o", dbg_lat, 2);
		if (cpu_t <= dbg_t)
			stop_run("The CPU write finished before the debug write");
	endtask

	task automatic read_until(input int mst, input logic [31:0] adr, input logic [31:0] exp);
		soc_pkg::wb_s2m_t rsp;
		int               lat;
		int               n;
		string            name;
		name = (mst == 1) ? "dbg_s2m_o" : "cpu_s2m_o";
		n = 0;
		rsp = '0;
		rsp.dat = ~exp;
		while (rsp.dat !== exp) begin
			if (n == POLL_LIMIT)
				stop_run($sformatf("Reads of %h never returned %h", adr, exp));
			transfer(mst, 1'b0, adr, 32'h0, 4'hf, rsp, lat);
			check_s2m(name, rsp, {exp, 1'b1, 1'b0}, 1'b0);
			check_latency(name, lat, 2);
			n++;
		end
	endtask

	task automatic expect_byte(input logic [7:0] exp);
		int n;
		n = 0;
		while (rx_bytes.size() == 0) begin
			if (n == BYTE_TIMEOUT)
				stop_run("No byte arrived on uart_tx_o in time");
			@(negedge wb_clk);
			n++;
		end
		check_byte(rx_bytes.pop_front(), exp);
	endtask

	//////////////////////////////
	// Serial line decoder
	//////////////////////////////

	// Start bit found half a clock in and later samples land mid-bit
	initial begin : serial_rx
		logic [7:0] b;
		forever begin
			@(negedge wb_clk);
			if (rst_n && uart_tx === 1'b0) begin
				repeat (soc_pkg::UART_DIVISOR / 2) @(negedge wb_clk);
				if (uart_tx !== 1'b0)
					stop_run("Start bit on uart_tx_o ended early");
				for (int i = 0; i < 8; i++) begin
					repeat (soc_pkg::UART_DIVISOR) @(negedge wb_clk);
					b[i] = uart_tx;
				end
				repeat (soc_pkg::UART_DIVISOR) @(negedge wb_clk);
				if (uart_tx !== 1'b1)
					stop_run("Stop bit missing on uart_tx_o");
				rx_bytes.push_back(b);
			end
		end
	end

	//////////////////////////////
	// Trace sequencer
	//////////////////////////////

	initial begin : run_trace
		int          fd;
		int          cnt;
		string       line;
		int          op;
		int          mst;
		int          lat;
		logic        we;
		logic        err;
		logic [31:0] adr;
		logic [31:0] dat;
		logic [31:0] exp;
		logic [3:0]  sel;

		wb_clk  = 1'b0;
		rst_n   = 1'b0;
		cpu_m2s = '0;
		dbg_m2s = '0;
		repeat (5) @(posedge wb_clk);
		rst_n <= 1'b1;

		fd = $fopen("bench/soc_trace.txt", "r");
		if (fd == 0)
			stop_run("Cannot open bench/soc_trace.txt");
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
			              op, mst, we, adr, dat, sel, exp, err, lat);
			if (cnt != 9)
				stop_run($sformatf("Malformed trace line: %s", line));
			case (op)
				0: access(mst, we, adr, dat, sel, exp, err, lat);
				1: both_write(adr, dat, exp, sel);
				2: begin
					@(negedge wb_clk);
					check_irq(irq, exp);
				end
				3: expect_byte(exp[7:0]);
				4: read_until(mst, adr, exp);
				default: stop_run($sformatf("Unknown trace operation %0d", op));
			endcase
		end
		$fclose(fd);

		if (rx_bytes.size() != 0) begin
			stop_run("Unexpected extra bytes on uart_tx_o");
		end else begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== bench/soc_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module soc_assertions (
	input wire                     wb_clk_i,
	input wire                     rst_n_i,
	input wire soc_pkg::wb_m2s_t   cpu_m2s_i,
	input wire soc_pkg::wb_m2s_t   dbg_m2s_i,
	input wire soc_pkg::wb_s2m_t   cpu_s2m_i,
	input wire soc_pkg::wb_s2m_t   dbg_s2m_i,
	input wire soc_pkg::wb_m2s_t   ram_m2s_i,
	input wire soc_pkg::wb_m2s_t   uart_m2s_i,
	input wire soc_pkg::ic_state_e state_i
);

	// Responses go to one master at a time
	a_one_rsp: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
		!((cpu_s2m_i.ack || cpu_s2m_i.err) && (dbg_s2m_i.ack || dbg_s2m_i.err)))
		else $error("Both masters received a response in the same cycle");

	a_ram_stb: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
		ram_m2s_i.stb |-> ram_m2s_i.cyc)
		else $error("RAM saw stb without cyc");

	a_uart_stb: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
		uart_m2s_i.stb |-> uart_m2s_i.cyc)
		else $error("UART saw stb without cyc");

	// Grant is registered so idle shows one clock later
	a_idle: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
		(!cpu_m2s_i.cyc && !dbg_m2s_i.cyc) |=> state_i == soc_pkg::IC_IDLE)
		else $error("Arbiter not idle with no master holding cyc");

endmodule

bind wb_intercon soc_assertions u_assertions (
	.wb_clk_i   (wb_clk_i),
	.rst_n_i    (rst_n_i),
	.cpu_m2s_i  (cpu_m2s_i),
	.dbg_m2s_i  (dbg_m2s_i),
	.cpu_s2m_i  (cpu_s2m_o),
	.dbg_s2m_i  (dbg_s2m_o),
	.ram_m2s_i  (ram_m2s_o),
	.uart_m2s_i (uart_m2s_o),
	.state_i    (state_q)
);

`default_nettype wire

// ==== verilog/soc_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module soc_top (
	input  wire                     wb_clk_i,
	input  wire                     rst_n_i,

	// External bus masters
	input  wire soc_pkg::wb_m2s_t   cpu_m2s_i,
	output soc_pkg::wb_s2m_t        cpu_s2m_o,
	input  wire soc_pkg::wb_m2s_t   dbg_m2s_i,
	output soc_pkg::wb_s2m_t        dbg_s2m_o,

	output logic                    uart_tx_o,
	output logic [31:0]             irq_o
);

	soc_pkg::wb_m2s_t ram_m2s;
	soc_pkg::wb_s2m_t ram_s2m;
	soc_pkg::wb_m2s_t uart_m2s;
	soc_pkg::wb_s2m_t uart_s2m;
	logic             uart_irq;

	//////////////////////////////
	// Interconnect
	//////////////////////////////

	wb_intercon u_intercon (
		.wb_clk_i   (wb_clk_i),
		.rst_n_i    (rst_n_i),
		.cpu_m2s_i  (cpu_m2s_i),
		.cpu_s2m_o  (cpu_s2m_o),
		.dbg_m2s_i  (dbg_m2s_i),
		.dbg_s2m_o  (dbg_s2m_o),
		.ram_m2s_o  (ram_m2s),
		.ram_s2m_i  (ram_s2m),
		.uart_m2s_o (uart_m2s),
		.uart_s2m_i (uart_s2m)
	);

	//////////////////////////////
	// Slaves
	//////////////////////////////

	wb_ram u_ram (
		.wb_clk_i (wb_clk_i),
		.rst_n_i  (rst_n_i),
		.wb_m2s_i (ram_m2s),
		.wb_s2m_o (ram_s2m)
	);

	wb_uart_tx u_uart (
		.wb_clk_i (wb_clk_i),
		.rst_n_i  (rst_n_i),
		.wb_m2s_i (uart_m2s),
		.wb_s2m_o (uart_s2m),
		.tx_o     (uart_tx_o),
		.irq_o    (uart_irq)
	);

	// Only the UART drives a line in the vector
	assign irq_o = {31'b0, uart_irq} << soc_pkg::IRQ_UART;

endmodule

`default_nettype wire

// ==== verilog/wb_uart_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_uart_tx (
	input  wire                     wb_clk_i,
	input  wire                     rst_n_i,
	input  wire soc_pkg::wb_m2s_t   wb_m2s_i,
	output soc_pkg::wb_s2m_t        wb_s2m_o,
	output logic                    tx_o,
	output logic                    irq_o
);

	logic                              ack_q;
	logic                              start_q;
	logic                              busy_q;
	logic                              ier_q;
	logic [7:0]                        tx_byte_q;
	logic [9:0]                        shift_q;
	logic [3:0]                        bit_cnt_q;
	logic [soc_pkg::UART_DIV_BITS-1:0] div_cnt_q;
	logic [31:0]                       rdat_q;
	logic                              busy;
	logic                              req;
	logic                              word1;
	logic                              accept;
	logic                              data_wr;

	//////////////////////////////
	// Bus side
	//////////////////////////////

	// Busy from the accepting edge, not only once the frame runs
	assign busy  = busy_q | start_q;
	assign req   = wb_m2s_i.cyc & wb_m2s_i.stb & ~ack_q;
	assign word1 = wb_m2s_i.adr[2];

	// Data write stalls until the shifter is free
	assign accept  = req & ~(wb_m2s_i.we & ~word1 & busy);
	assign data_wr = accept & wb_m2s_i.we & ~word1 & wb_m2s_i.sel[0];

	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_q   <= 1'b0;
			start_q <= 1'b0;
			ier_q   <= 1'b0;
		end else begin
			ack_q   <= accept;
			start_q <= data_wr;
			if (accept && wb_m2s_i.we && word1 && wb_m2s_i.sel[0])
				ier_q <= wb_m2s_i.dat[0];
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (data_wr)
			tx_byte_q <= wb_m2s_i.dat[7:0];
		if (accept)
			rdat_q <= word1 ? {31'b0, ier_q} : {31'b0, busy};
	end

	always_comb begin
		wb_s2m_o.dat = rdat_q;
		wb_s2m_o.ack = ack_q;
		wb_s2m_o.err = 1'b0;
	end

	//////////////////////////////
	// Serial shifter
	//////////////////////////////

	// Frame is start, 8 data bits LSB first, stop
	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			shift_q   <= '1;
			busy_q    <= 1'b0;
			bit_cnt_q <= '0;
			div_cnt_q <= '0;
		end else if (start_q) begin
			shift_q   <= {1'b1, tx_byte_q, 1'b0};
			busy_q    <= 1'b1;
			bit_cnt_q <= '0;
			div_cnt_q <= '0;
		end else if (busy_q) begin
			if (div_cnt_q == soc_pkg::UART_DIV_LAST) begin
				div_cnt_q <= '0;
				shift_q   <= {1'b1, shift_q[9:1]};
				bit_cnt_q <= bit_cnt_q + 4'd1;
				// Stop bit done
				if (bit_cnt_q == 4'd9)
					busy_q <= 1'b0;
			end else begin
				div_cnt_q <= div_cnt_q + 1'b1;
			end
		end
	end

	// Line idles high since ones shift in
	assign tx_o  = shift_q[0];
	assign irq_o = ier_q & ~busy;

endmodule

`default_nettype wire

// ==== verilog/wb_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_ram (
	input  wire                     wb_clk_i,
	input  wire                     rst_n_i,
	input  wire soc_pkg::wb_m2s_t   wb_m2s_i,
	output soc_pkg::wb_s2m_t        wb_s2m_o
);

	logic [31:0]                       mem [0:(1 << soc_pkg::RAM_ADDR_BITS)-1];
	logic [soc_pkg::RAM_ADDR_BITS-1:0] word_adr;
	logic [31:0]                       rdat_q;
	logic                              ack_q;
	logic                              access;

	assign word_adr = wb_m2s_i.adr[soc_pkg::RAM_ADDR_BITS+1:2];

	// Ack blocks a second access while strobe is still held
	assign access = wb_m2s_i.cyc & wb_m2s_i.stb & ~ack_q;

	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			ack_q <= 1'b0;
		else
			ack_q <= access;
	end

	// Byte lanes follow sel
	always_ff @(posedge wb_clk_i) begin
		if (access && wb_m2s_i.we) begin
			for (int i = 0; i < 4; i++) begin
				if (wb_m2s_i.sel[i])
					mem[word_adr][8*i +: 8] <= wb_m2s_i.dat[8*i +: 8];
			end
		end
		if (access)
			rdat_q <= mem[word_adr];
	end

	always_comb begin
		wb_s2m_o.dat = rdat_q;
		wb_s2m_o.ack = ack_q;
		wb_s2m_o.err = 1'b0;
	end

endmodule

`default_nettype wire

// ==== verilog/wb_intercon.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_intercon (
	input  wire                     wb_clk_i,
	input  wire                     rst_n_i,

	// Masters
	input  wire soc_pkg::wb_m2s_t   cpu_m2s_i,
	output soc_pkg::wb_s2m_t        cpu_s2m_o,
	input  wire soc_pkg::wb_m2s_t   dbg_m2s_i,
	output soc_pkg::wb_s2m_t        dbg_s2m_o,

	// Slaves
	output soc_pkg::wb_m2s_t        ram_m2s_o,
	input  wire soc_pkg::wb_s2m_t   ram_s2m_i,
	output soc_pkg::wb_m2s_t        uart_m2s_o,
	input  wire soc_pkg::wb_s2m_t   uart_s2m_i
);

	soc_pkg::ic_state_e  state_q;
	soc_pkg::ic_state_e  state_d;
	soc_pkg::slave_sel_e slv_sel;
	soc_pkg::wb_m2s_t    gnt_m2s;
	soc_pkg::wb_s2m_t    gnt_s2m;
	logic                err_q;

	//////////////////////////////
	// Arbiter
	//////////////////////////////

	// Re-arbitrate once the owner lets go of cyc, debug wins ties
	always_comb begin
		state_d = state_q;
		if (state_q == soc_pkg::IC_IDLE || !gnt_m2s.cyc) begin
			if (dbg_m2s_i.cyc && dbg_m2s_i.stb)
				state_d = soc_pkg::IC_DBG;
			else if (cpu_m2s_i.cyc && cpu_m2s_i.stb)
				state_d = soc_pkg::IC_CPU;
			else
				state_d = soc_pkg::IC_IDLE;
		end
	end

	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			state_q <= soc_pkg::IC_IDLE;
		else
			state_q <= state_d;
	end

	// Bundle of whoever holds the grant
	always_comb begin
		case (state_q)
			soc_pkg::IC_DBG: gnt_m2s = dbg_m2s_i;
			soc_pkg::IC_CPU: gnt_m2s = cpu_m2s_i;
			default:         gnt_m2s = '0;
		endcase
	end

	//////////////////////////////
	// Address decoder
	//////////////////////////////

	always_comb begin
		if (gnt_m2s.adr[31 -: soc_pkg::RAM_MASK_BITS] ==
		    soc_pkg::RAM_BASE[31 -: soc_pkg::RAM_MASK_BITS])
			slv_sel = soc_pkg::SLV_RAM;
		else if (gnt_m2s.adr[31 -: soc_pkg::UART_MASK_BITS] ==
		         soc_pkg::UART_BASE[31 -: soc_pkg::UART_MASK_BITS])
			slv_sel = soc_pkg::SLV_UART;
		else
			slv_sel = soc_pkg::SLV_NONE;
	end

	// Only the selected slave sees the cycle
	assign ram_m2s_o  = (slv_sel == soc_pkg::SLV_RAM)  ? gnt_m2s : '0;
	assign uart_m2s_o = (slv_sel == soc_pkg::SLV_UART) ? gnt_m2s : '0;

	// Unmapped access, single cycle error
	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			err_q <= 1'b0;
		else
			err_q <= gnt_m2s.cyc && gnt_m2s.stb &&
			         slv_sel == soc_pkg::SLV_NONE && !err_q;
	end

	//////////////////////////////
	// Response routing
	//////////////////////////////

	always_comb begin
		case (slv_sel)
			soc_pkg::SLV_RAM:  gnt_s2m = ram_s2m_i;
			soc_pkg::SLV_UART: gnt_s2m = uart_s2m_i;
			default: begin
				gnt_s2m     = '0;
				gnt_s2m.err = err_q;
			end
		endcase
	end

	assign cpu_s2m_o = (state_q == soc_pkg::IC_CPU) ? gnt_s2m : '0;
	assign dbg_s2m_o = (state_q == soc_pkg::IC_DBG) ? gnt_s2m : '0;

endmodule

`default_nettype wire

// ==== verilog/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

	//////////////////////////////
	// Wishbone bundles
	//////////////////////////////

	// Master to slave, classic cycle only
	typedef struct packed {
		logic [31:0] adr;
		logic [31:0] dat;
		logic [3:0]  sel;
		logic        we;
		logic        cyc;
		logic        stb;
	} wb_m2s_t;

	// Slave to master
	typedef struct packed {
		logic [31:0] dat;
		logic        ack;
		logic        err;
	} wb_s2m_t;

	//////////////////////////////
	// Enumerations
	//////////////////////////////

	typedef enum logic [1:0] {
		IC_IDLE,
		IC_DBG,
		IC_CPU
	} ic_state_e;

	typedef enum logic [1:0] {
		SLV_RAM,
		SLV_UART,
		SLV_NONE
	} slave_sel_e;

	//////////////////////////////
	// Address map
	//////////////////////////////

	// Main RAM, 256 words
	localparam logic [31:0] RAM_BASE      = 32'h0000_0000;
	localparam int          RAM_ADDR_BITS = 8;
	localparam int          RAM_MASK_BITS = 32 - (RAM_ADDR_BITS + 2);

	// UART, word 0 data/status, word 1 irq enable
	localparam logic [31:0] UART_BASE      = 32'h9000_0000;
	localparam int          UART_MASK_BITS = 29;

	// Serial bit timing
	localparam int                       UART_DIVISOR  = 4;
	localparam int                       UART_DIV_BITS = $clog2(UART_DIVISOR);
	localparam logic [UART_DIV_BITS-1:0] UART_DIV_LAST = UART_DIV_BITS'(UART_DIVISOR - 1);

	// Interrupt vector position
	localparam int IRQ_UART = 2;

endpackage

`default_nettype wire
